// File: design/mips_pkg.sv
package mips_pkg;

    // Fixed by the instruction set
    localparam int DATA_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        F_SLL = 6'h00,
        F_SRL = 6'h02,
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } fwd_sel_e;

    // Controls carried from decode into execute
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    alu_src_imm;
        logic    shift;
        logic    reg_dst_rd;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rd1;
        word_t     rd2;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        word_t     sign_imm;
        word_t     shamt;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        logic      mem_write;
        word_t     alu_out;
        word_t     write_data;
        reg_addr_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_out;
        word_t     read_data;
        reg_addr_t dst;
    } mem_wb_t;

    // Data memory port, driven from the memory stage
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

    // Register file write port
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_wr_t;

    // Bubble: no register write, no store
    localparam ctrl_t NOP_CTRL = '{
        reg_write:   1'b0,
        mem_to_reg:  1'b0,
        mem_write:   1'b0,
        alu_src_imm: 1'b0,
        shift:       1'b0,
        reg_dst_rd:  1'b0,
        alu_op:      ALU_ADD
    };

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  reg_wr_t   wr_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    output word_t     rd1_o,
    output word_t     rd2_o
);

    word_t regs [NUM_REGS];

    // Single write port, register 0 never stored
    always_ff @(posedge clk_i)
    begin
        if (wr_i.en && (wr_i.addr != '0))
        begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Write-first reads so decode sees the value retiring this cycle
    function automatic word_t read_port(reg_addr_t ra, reg_wr_t wr, word_t stored);
        if (ra == '0)
            return '0;
        else if (wr.en && (wr.addr == ra))
            return wr.data;
        else
            return stored;
    endfunction

    assign rd1_o = read_port(ra1_i, wr_i, regs[ra1_i]);
    assign rd2_o = read_port(ra2_i, wr_i, regs[ra2_i]);

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
)
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  word_t instr_i,
    output word_t pc_o,
    output word_t instr_d_o,
    output word_t pc_plus4_d_o
);

    word_t pc_plus4;

    // Sequential fetch only
    assign pc_plus4 = pc_o + word_t'(4);

    // PC register, frozen while a load-use stall is pending
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            pc_o <= RESET_PC;
        end
        else if (!stall_i)
        begin
            pc_o <= pc_plus4;
        end
    end

    // Fetch/decode register
    // All-zero word decodes as sll $0, $0, 0
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            instr_d_o    <= '0;
            pc_plus4_d_o <= '0;
        end
        else if (!stall_i)
        begin
            instr_d_o    <= instr_i;
            pc_plus4_d_o <= pc_plus4;
        end
    end

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
    import mips_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      flush_i,
    input  word_t     instr_i,
    input  reg_wr_t   wb_i,
    output reg_addr_t rs_o,
    output reg_addr_t rt_o,
    output id_ex_t    id_ex_o
);

    opcode_e opcode;
    funct_e  funct;
    ctrl_t   ctrl_dec;
    word_t   rd1;
    word_t   rd2;
    id_ex_t  id_ex_d;

    // Instruction fields
    assign opcode = opcode_e'(instr_i[31:26]);
    assign funct  = funct_e'(instr_i[5:0]);
    assign rs_o   = instr_i[25:21];
    assign rt_o   = instr_i[20:16];

    // Written in writeback, read here
    reg_file reg_file_inst (
        .clk_i  (clk_i),
        .wr_i   (wb_i),
        .ra1_i  (rs_o),
        .ra2_i  (rt_o),
        .rd1_o  (rd1),
        .rd2_o  (rd2)
    );

    // Main controller, anything unrecognised falls back to a bubble
    always_comb
    begin
        ctrl_dec = NOP_CTRL;
        case (opcode)
            OP_RTYPE:
            begin
                ctrl_dec.reg_write  = 1'b1;
                ctrl_dec.reg_dst_rd = 1'b1;
                case (funct)
                    F_ADD: ctrl_dec.alu_op = ALU_ADD;
                    F_SUB: ctrl_dec.alu_op = ALU_SUB;
                    F_AND: ctrl_dec.alu_op = ALU_AND;
                    F_OR:  ctrl_dec.alu_op = ALU_OR;
                    F_SLT: ctrl_dec.alu_op = ALU_SLT;
                    F_SLL:
                    begin
                        ctrl_dec.alu_op = ALU_SLL;
                        ctrl_dec.shift  = 1'b1;
                    end
                    F_SRL:
                    begin
                        ctrl_dec.alu_op = ALU_SRL;
                        ctrl_dec.shift  = 1'b1;
                    end
                    default: ctrl_dec = NOP_CTRL;
                endcase
            end
            OP_LW:
            begin
                ctrl_dec.reg_write   = 1'b1;
                ctrl_dec.mem_to_reg  = 1'b1;
                ctrl_dec.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                ctrl_dec.mem_write   = 1'b1;
                ctrl_dec.alu_src_imm = 1'b1;
            end
            OP_ADDI:
            begin
                ctrl_dec.reg_write   = 1'b1;
                ctrl_dec.alu_src_imm = 1'b1;
            end
            default: ctrl_dec = NOP_CTRL;
        endcase
    end

    // Next decode/execute contents, bubble on load-use
    always_comb
    begin
        id_ex_d.ctrl     = flush_i ? NOP_CTRL : ctrl_dec;
        id_ex_d.rd1      = rd1;
        id_ex_d.rd2      = rd2;
        id_ex_d.rs       = rs_o;
        id_ex_d.rt       = rt_o;
        id_ex_d.rd       = instr_i[15:11];
        // Immediate sign-extended, shamt zero-extended
        id_ex_d.sign_imm = {{(DATA_W-16){instr_i[15]}}, instr_i[15:0]};
        id_ex_d.shamt    = word_t'(instr_i[10:6]);
    end

    // Decode/execute register
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            id_ex_o      <= '0;
            id_ex_o.ctrl <= NOP_CTRL;
        end
        else
        begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import mips_pkg::*;
(
    input  id_ex_t    id_ex_i,
    input  reg_addr_t rs_d_i,
    input  reg_addr_t rt_d_i,
    input  ex_mem_t   ex_mem_i,
    input  reg_wr_t   wb_i,
    output fwd_sel_e  fwd_a_o,
    output fwd_sel_e  fwd_b_o,
    output logic      stall_o,
    output logic      flush_o
);

    logic load_use;

    // Youngest producer wins, register 0 never forwarded
    function automatic fwd_sel_e fwd_select(reg_addr_t src, ex_mem_t em, reg_wr_t wb);
        if ((src != '0) && em.reg_write && (em.dst == src))
            return FWD_MEM;
        else if ((src != '0) && wb.en && (wb.addr == src))
            return FWD_WB;
        else
            return FWD_NONE;
    endfunction

    assign fwd_a_o = fwd_select(id_ex_i.rs, ex_mem_i, wb_i);
    assign fwd_b_o = fwd_select(id_ex_i.rt, ex_mem_i, wb_i);

    // Load in execute feeding the instruction in decode
    assign load_use = id_ex_i.ctrl.mem_to_reg &&
                      ((id_ex_i.rt == rs_d_i) || (id_ex_i.rt == rt_d_i));

    // Hold fetch/decode, bubble into execute
    assign stall_o = load_use;
    assign flush_o = load_use;

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import mips_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  id_ex_t   id_ex_i,
    input  fwd_sel_e fwd_a_i,
    input  fwd_sel_e fwd_b_i,
    input  reg_wr_t  wb_i,
    output ex_mem_t  ex_mem_o
);

    word_t     src_a;
    word_t     src_b;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_y;
    reg_addr_t dst;
    ex_mem_t   ex_mem_d;

    // Operand bypass from memory stage or writeback
    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a_i, id_ex_i.rd1, ex_mem_o.alu_out, wb_i.data);
    assign src_b = fwd_mux(fwd_b_i, id_ex_i.rd2, ex_mem_o.alu_out, wb_i.data);

    // Shifts take rt as the value and shamt as the amount
    assign alu_a = id_ex_i.ctrl.shift ? src_b : src_a;

    always_comb
    begin
        if (id_ex_i.ctrl.shift)
            alu_b = id_ex_i.shamt;
        else if (id_ex_i.ctrl.alu_src_imm)
            alu_b = id_ex_i.sign_imm;
        else
            alu_b = src_b;
    end

    // ALU
    always_comb
    begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD: alu_y = alu_a + alu_b;
            ALU_SUB: alu_y = alu_a - alu_b;
            ALU_AND: alu_y = alu_a & alu_b;
            ALU_OR:  alu_y = alu_a | alu_b;
            // Signed compare
            ALU_SLT: alu_y = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLL: alu_y = alu_a << alu_b[4:0];
            ALU_SRL: alu_y = alu_a >> alu_b[4:0];
            default: alu_y = '0;
        endcase
    end

    // rd for R-type, rt for immediates and loads
    assign dst = id_ex_i.ctrl.reg_dst_rd ? id_ex_i.rd : id_ex_i.rt;

    always_comb
    begin
        ex_mem_d.reg_write  = id_ex_i.ctrl.reg_write;
        ex_mem_d.mem_to_reg = id_ex_i.ctrl.mem_to_reg;
        ex_mem_d.mem_write  = id_ex_i.ctrl.mem_write;
        ex_mem_d.alu_out    = alu_y;
        // Store data is the forwarded rt
        ex_mem_d.write_data = src_b;
        ex_mem_d.dst        = dst;
    end

    // Execute/memory register
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ex_mem_o <= '0;
        end
        else
        begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

// File: design/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit
    import mips_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  ex_mem_t ex_mem_i,
    input  word_t   read_data_i,
    output reg_wr_t wb_o
);

    mem_wb_t mem_wb;

    // Memory/writeback register, load data sampled here
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            mem_wb <= '0;
        end
        else
        begin
            mem_wb.reg_write  <= ex_mem_i.reg_write;
            mem_wb.mem_to_reg <= ex_mem_i.mem_to_reg;
            mem_wb.alu_out    <= ex_mem_i.alu_out;
            mem_wb.read_data  <= read_data_i;
            mem_wb.dst        <= ex_mem_i.dst;
        end
    end

    // Result select, loads take memory data
    assign wb_o.en   = mem_wb.reg_write;
    assign wb_o.addr = mem_wb.dst;
    assign wb_o.data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_out;

endmodule

// File: design/mips_core.sv
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
)
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  word_t     instr_i,
    input  word_t     read_data_i,
    output word_t     pc_o,
    output dmem_req_t dmem_o
);

    // Fetch to decode
    word_t     instr_d;
    reg_addr_t rs_d;
    reg_addr_t rt_d;

    // Stage registers and writeback port
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    reg_wr_t   wb;

    // Hazard controls
    logic      stall;
    logic      flush;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    // PC+4 in decode, reserved for a branch target adder
    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_inst (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall),
        .instr_i      (instr_i),
        .pc_o         (pc_o),
        .instr_d_o    (instr_d),
        .pc_plus4_d_o ()
    );

    decode_unit decode_unit_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (flush),
        .instr_i  (instr_d),
        .wb_i     (wb),
        .rs_o     (rs_d),
        .rt_o     (rt_d),
        .id_ex_o  (id_ex)
    );

    hazard_unit hazard_unit_inst (
        .id_ex_i  (id_ex),
        .rs_d_i   (rs_d),
        .rt_d_i   (rt_d),
        .ex_mem_i (ex_mem),
        .wb_i     (wb),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b),
        .stall_o  (stall),
        .flush_o  (flush)
    );

    execute_unit execute_unit_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .id_ex_i  (id_ex),
        .fwd_a_i  (fwd_a),
        .fwd_b_i  (fwd_b),
        .wb_i     (wb),
        .ex_mem_o (ex_mem)
    );

    // Memory stage drives the data port directly
    assign dmem_o = '{addr: ex_mem.alu_out, wdata: ex_mem.write_data, we: ex_mem.mem_write};

    writeback_unit writeback_unit_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ex_mem_i    (ex_mem),
        .read_data_i (read_data_i),
        .wb_o        (wb)
    );

endmodule

// File: tests/mips_core_assertions.sv
`timescale 1ns/1ps

module mips_core_assertions
    import mips_pkg::*;
(
    input logic      clk_i,
    input logic      arst_n_i,
    input logic      stall_i,
    input word_t     pc_i,
    input dmem_req_t dmem_i
);

    // Count of failed assertions
    int unsigned fail_count = 0;

    // Store enable always driven out of reset
    we_known: assert property (@(posedge clk_i) arst_n_i |-> !$isunknown(dmem_i.we))
        else
        begin
            fail_count++;
            $error("dmem_o.we is unknown");
        end

    // Load-use stall freezes the PC
    pc_hold: assert property (@(posedge clk_i)
        (arst_n_i && stall_i) |=> (!arst_n_i || (pc_i == $past(pc_i))))
        else
        begin
            fail_count++;
            $error("pc_o moved during a stall");
        end

    // Sequential fetch otherwise
    pc_step: assert property (@(posedge clk_i)
        (arst_n_i && !stall_i) |=> (!arst_n_i || (pc_i == $past(pc_i) + 32'd4)))
        else
        begin
            fail_count++;
            $error("pc_o did not advance by four");
        end

endmodule

bind mips_core mips_core_assertions assertions_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stall_i  (stall),
    .pc_i     (pc_o),
    .dmem_i   (dmem_o)
);

// File: tests/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb
    import mips_pkg::*;
;

    localparam word_t RESET_PC       = 32'h0000_0040;
    localparam word_t SEED           = 32'h1d851404;
    localparam int    TIMEOUT_CYCLES = 200;

    logic      clk_i;
    logic      arst_n_i;
    word_t     instr_i;
    word_t     read_data_i;
    word_t     pc_o;
    dmem_req_t dmem_o;

    // Instruction and data memories of 64 words each
    word_t     imem [64];
    word_t     dmem [64];
    word_t     imem_off;

    // Architectural model kept alongside the DUT
    word_t     model_regs [32];
    word_t     model_mem [64];
    word_t     rng_state;
    int        prog_len;
    dmem_req_t exp_q [$];
    dmem_req_t log_q [$];

    mips_core #(
        .RESET_PC(RESET_PC)
    ) mips_core_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .instr_i     (instr_i),
        .read_data_i (read_data_i),
        .pc_o        (pc_o),
        .dmem_o      (dmem_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Untouched data words depend on the full address
    function automatic word_t fill_word(word_t addr);
        return addr ^ 32'h5ca1_ab1e;
    endfunction

    // Same-cycle instruction return with no-ops past the program
    assign imem_off = pc_o - RESET_PC;
    assign instr_i  = (imem_off < 32'd256) ? imem[imem_off[7:2]] : '0;

    // Combinational load data
    assign read_data_i = (dmem_o.addr < 32'd256) ? dmem[dmem_o.addr[7:2]]
                                                 : fill_word(dmem_o.addr);

    // Store log and memory update at the end of the memory-stage cycle
    always @(posedge clk_i)
    begin
        if (arst_n_i && (dmem_o.we === 1'b1))
        begin
            log_q.push_back(dmem_o);
            if (dmem_o.addr < 32'd256)
                dmem[dmem_o.addr[7:2]] <= dmem_o.wdata;
        end
    end

    function automatic word_t xorshift(word_t x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [15:0] rand_imm();
        rng_state = xorshift(rng_state);
        return rng_state[15:0];
    endfunction

    function automatic word_t sext16(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Stop at the first assertion failure
    always @(negedge clk_i)
    begin
        if (mips_core_inst.assertions_inst.fail_count != 0)
        begin
            $display("An assertion on the DUT failed");
            abort_run();
        end
    end

    task automatic check_word(string name, word_t got, word_t expected);
        if (got !== expected)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_store(dmem_req_t got, dmem_req_t expected);
        if (got !== expected)
        begin
            $display("ERROR at %0t: dmem_o store addr %h wdata %h we %b, expected %h %h %b",
                     $time, got.addr, got.wdata, got.we,
                     expected.addr, expected.wdata, expected.we);
            abort_run();
        end
    endtask

    // Hold reset while clearing the program and both logs
    task automatic start_program();
        int i;
        @(posedge clk_i);
        arst_n_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        for (i = 0; i < 64; i++)
            imem[i[5:0]] = '0;
        prog_len = 0;
        exp_q.delete();
        log_q.delete();
    endtask

    task automatic release_reset();
        @(posedge clk_i);
        arst_n_i <= 1'b1;
    endtask

    task automatic emit_word(word_t w);
        imem[prog_len[5:0]] = w;
        prog_len++;
    endtask

    // Register 0 stays zero in the model
    task automatic write_model_reg(reg_addr_t r, word_t v);
        if (r != 5'd0)
            model_regs[r] = v;
    endtask

    task automatic addi_op(reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        emit_word({OP_ADDI, rs, rt, imm});
        write_model_reg(rt, model_regs[rs] + sext16(imm));
    endtask

    task automatic rtype_op(funct_e f, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                            logic [4:0] shamt);
        word_t a;
        word_t b;
        word_t y;
        a = model_regs[rs];
        b = model_regs[rt];
        case (f)
            F_ADD:   y = a + b;
            F_SUB:   y = a - b;
            F_AND:   y = a & b;
            F_OR:    y = a | b;
            F_SLT:   y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            // Shifts act on rt
            F_SLL:   y = b << shamt;
            F_SRL:   y = b >> shamt;
            default: y = '0;
        endcase
        emit_word({OP_RTYPE, rs, rt, rd, shamt, f});
        write_model_reg(rd, y);
    endtask

    task automatic store_op(reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        dmem_req_t req;
        req.addr  = model_regs[rs] + sext16(imm);
        req.wdata = model_regs[rt];
        req.we    = 1'b1;
        emit_word({OP_SW, rs, rt, imm});
        exp_q.push_back(req);
        model_mem[req.addr[7:2]] = req.wdata;
    endtask

    task automatic load_op(reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
        word_t addr;
        addr = model_regs[rs] + sext16(imm);
        emit_word({OP_LW, rs, rt, imm});
        write_model_reg(rt, model_mem[addr[7:2]]);
    endtask

    task automatic wait_for_stores(int count);
        int cycles;
        cycles = 0;
        while (log_q.size() < count)
        begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("Timed out waiting for %0d stores, only %0d seen", count, log_q.size());
                abort_run();
            end
        end
    endtask

    task automatic wait_for_pc(word_t target);
        int cycles;
        cycles = 0;
        while (pc_o < target)
        begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
            begin
                $display("Timed out waiting for the PC to reach %h", target);
                abort_run();
            end
        end
    endtask

    // Run until the program has drained and compare the store log
    task automatic run_program();
        word_t end_pc;
        int    i;
        end_pc = RESET_PC + word_t'((prog_len + 8) * 4);
        release_reset();
        wait_for_stores(exp_q.size());
        wait_for_pc(end_pc);
        check_word("store count", word_t'(log_q.size()), word_t'(exp_q.size()));
        for (i = 0; i < exp_q.size(); i++)
            check_store(log_q[i], exp_q[i]);
    endtask

    task automatic reset_behaviour();
        int i;
        $display("Checking reset state");
        start_program();
        @(negedge clk_i);
        check_word("pc_o", pc_o, RESET_PC);
        check_word("dmem_o.we", word_t'(dmem_o.we), '0);
        release_reset();
        // Only reset contents in the pipeline
        for (i = 0; i < 4; i++)
        begin
            @(negedge clk_i);
            check_word("pc_o", pc_o, RESET_PC + word_t'(i * 4));
            check_word("dmem_o.we", word_t'(dmem_o.we), '0);
        end
    endtask

    task automatic alu_results();
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        logic [15:0] amount;
        $display("Checking R-type results");
        start_program();
        imm_a  = rand_imm();
        imm_b  = rand_imm();
        amount = rand_imm();
        addi_op(5'd1, 5'd0, imm_a);
        addi_op(5'd2, 5'd0, imm_b);
        rtype_op(F_ADD, 5'd3, 5'd1, 5'd2, 5'd0);
        store_op(5'd3, 5'd0, 16'd0);
        rtype_op(F_SUB, 5'd4, 5'd1, 5'd2, 5'd0);
        store_op(5'd4, 5'd0, 16'd4);
        rtype_op(F_AND, 5'd5, 5'd1, 5'd2, 5'd0);
        store_op(5'd5, 5'd0, 16'd8);
        rtype_op(F_OR, 5'd6, 5'd1, 5'd2, 5'd0);
        store_op(5'd6, 5'd0, 16'd12);
        rtype_op(F_SLT, 5'd7, 5'd1, 5'd2, 5'd0);
        store_op(5'd7, 5'd0, 16'd16);
        rtype_op(F_SLL, 5'd8, 5'd0, 5'd1, amount[4:0]);
        store_op(5'd8, 5'd0, 16'd20);
        rtype_op(F_SRL, 5'd9, 5'd0, 5'd2, amount[9:5]);
        store_op(5'd9, 5'd0, 16'd24);
        run_program();
    endtask

    task automatic dependency_chains();
        $display("Checking dependent instructions");
        start_program();
        addi_op(5'd1, 5'd0, rand_imm());
        // r1 one back
        addi_op(5'd2, 5'd1, rand_imm());
        // r2 one back and r1 two back
        rtype_op(F_SUB, 5'd3, 5'd2, 5'd1, 5'd0);
        // r1 three back goes through the register file
        rtype_op(F_OR, 5'd4, 5'd1, 5'd3, 5'd0);
        store_op(5'd4, 5'd0, 16'd40);
        store_op(5'd3, 5'd0, 16'd36);
        store_op(5'd2, 5'd0, 16'd32);
        run_program();
    endtask

    task automatic load_store_pairs();
        $display("Checking loads and stores");
        start_program();
        addi_op(5'd5, 5'd0, rand_imm());
        store_op(5'd5, 5'd0, 16'd48);
        load_op(5'd6, 5'd0, 16'd48);
        // Load-use on both sources
        rtype_op(F_ADD, 5'd7, 5'd6, 5'd6, 5'd0);
        store_op(5'd7, 5'd0, 16'd52);
        load_op(5'd8, 5'd0, 16'd52);
        store_op(5'd8, 5'd0, 16'd56);
        // Word never stored so the fill pattern comes back
        load_op(5'd10, 5'd0, 16'd200);
        store_op(5'd10, 5'd0, 16'd44);
        run_program();
    endtask

    task automatic zero_register_writes();
        $display("Checking register 0");
        start_program();
        addi_op(5'd0, 5'd0, rand_imm() | 16'h0001);
        rtype_op(F_ADD, 5'd0, 5'd1, 5'd2, 5'd0);
        store_op(5'd0, 5'd0, 16'd60);
        run_program();
    endtask

    task automatic unknown_opcode_skip();
        $display("Checking unknown opcodes");
        start_program();
        addi_op(5'd9, 5'd0, rand_imm());
        // Opcode 0x3f aimed at r9
        emit_word({6'h3f, 5'd0, 5'd9, 16'h1234});
        // R-type with an unused function code and rd of r9
        emit_word({6'h00, 5'd1, 5'd2, 5'd9, 5'd0, 6'h3f});
        store_op(5'd9, 5'd0, 16'd64);
        run_program();
    endtask

    initial
    begin
        int i;
        arst_n_i  = 1'b0;
        rng_state = SEED;
        prog_len  = 0;
        for (i = 0; i < 64; i++)
        begin
            imem[i[5:0]]      = '0;
            dmem[i[5:0]]      = fill_word(word_t'(i * 4));
            model_mem[i[5:0]] = fill_word(word_t'(i * 4));
        end
        for (i = 0; i < 32; i++)
            model_regs[i[4:0]] = '0;

        reset_behaviour();
        alu_results();
        dependency_chains();
        load_store_pairs();
        zero_register_writes();
        unknown_opcode_skip();

        if (mips_core_inst.assertions_inst.fail_count == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures during the run",
                     mips_core_inst.assertions_inst.fail_count);
            abort_run();
        end
    end

endmodule

// File: verilog.f
design/mips_pkg.sv
design/reg_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/hazard_unit.sv
design/execute_unit.sv
design/writeback_unit.sv
design/mips_core.sv
tests/mips_core_assertions.sv
tests/mips_core_tb.sv

// File: Makefile
# Verilator build and run of the pipelined MIPS core testbench

VERILATOR       ?= verilator
TOP             ?= mips_core_tb
FILE_LIST       ?= verilog.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
SIM_FLAGS       ?= +verilator+error+limit+100
PASS_MSG        ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VERILATOR_FLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
